// ==== verilog.f ====
+incdir+hw
hw/tetris_pkg.sv
hw/piece_if.sv
hw/board_if.sv
hw/piece_unit.sv
hw/board_store.sv
hw/game_control.sv
hw/tetris_core.sv
testbench/tetris_tb.sv

// ==== testbench/tetris_tb.sv ====
`timescale 1ns/1ps
`include "tetris_params.svh"

module tetris_tb;
	import tetris_pkg::*;

	localparam int N_TESTS = 18;
	localparam int TICK_CYCLES = 150;

	logic clk;
	logic reset;
	logic tick;
	logic start;
	logic left;
	logic right;
	logic rotate;
	logic down;
	piece_kind_e next_kind;
	logic [`ROW_W-1:0] row_sel;
	logic [`BOARD_COLS-1:0] row_bits;
	logic playing;
	logic game_over;
	logic [`LINES_W-1:0] lines;
	logic [`LEVEL_W-1:0] level;

	// scenario table, expected columns filled by the model
	string t_name [N_TESTS];
	bit t_start [N_TESTS];
	piece_kind_e t_kind [N_TESTS];  // kind spawned during the row
	bit t_left [N_TESTS];
	bit t_right [N_TESTS];
	bit t_down [N_TESTS];
	int t_rot [N_TESTS];            // rotate before this tick, 0 for none
	int t_ticks [N_TESTS];
	int t_row [N_TESTS];
	int t_exp_lines [N_TESTS];
	int t_exp_level [N_TESTS];
	bit t_exp_over [N_TESTS];
	logic [`BOARD_COLS-1:0] t_exp_row [N_TESTS];

	// reference board model
	logic [`BOARD_COLS-1:0] m_board [`BOARD_ROWS];
	int m_row [4];
	int m_col [4];
	int c_row [4];
	int c_col [4];
	int m_prow;
	int m_pcol;
	piece_kind_e m_kind;
	int m_lines;
	int m_level;
	int m_grav;
	bit m_playing;
	bit m_over;

	int n_added;
	int seed;
	int cycle_count;
	int cycle_limit;
	int pass_count;
	int fail_count;
	int test_errs;

	tetris_core u_dut (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.start     (start),
		.left      (left),
		.right     (right),
		.rotate    (rotate),
		.down      (down),
		.next_kind (next_kind),
		.row_sel   (row_sel),
		.row_bits  (row_bits),
		.playing   (playing),
		.game_over (game_over),
		.lines     (lines),
		.level     (level)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//============================================================
	// model
	//============================================================
	function automatic bit cand_fits();
		bit ok;
		ok = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (c_row[i] < 0 || c_row[i] >= `BOARD_ROWS) ok = 1'b0;
			else if (c_col[i] < 0 || c_col[i] >= `BOARD_COLS) ok = 1'b0;
			else if (m_board[c_row[i]][c_col[i]]) ok = 1'b0;
		end
		return ok;
	endfunction

	task automatic take_cand();
		for (int i = 0; i < 4; i++) begin
			m_row[i] = c_row[i];
			m_col[i] = c_col[i];
		end
	endtask

	task automatic model_spawn(input piece_kind_e k);
		cells_t sc;
		sc = spawn_cells[k];
		for (int i = 0; i < 4; i++) begin
			c_row[i] = int'(sc[i].row);
			c_col[i] = int'(sc[i].col);
		end
		m_kind = k;
		m_grav = 0;
		if (cand_fits()) begin
			take_cand();
			m_prow = (k == PIECE_I) ? 0 : 1; // I turns about its third cell
			m_pcol = (k == PIECE_I) ? 5 : 4;
			m_playing = 1'b1;
			m_over = 1'b0;
		end else begin
			m_playing = 1'b0;
			m_over = 1'b1;
		end
	endtask

	task automatic try_shift(input int dr, input int dc, output bit ok);
		for (int i = 0; i < 4; i++) begin
			c_row[i] = m_row[i] + dr;
			c_col[i] = m_col[i] + dc;
		end
		ok = cand_fits();
		if (ok) begin
			take_cand();
			m_prow = m_prow + dr;
			m_pcol = m_pcol + dc;
		end
	endtask

	task automatic try_rotate();
		for (int i = 0; i < 4; i++) begin
			c_row[i] = m_prow + (m_col[i] - m_pcol);
			c_col[i] = m_pcol - (m_row[i] - m_prow);
		end
		if (cand_fits()) take_cand();
	endtask

	task automatic model_lock(input piece_kind_e k);
		int n;
		int full;
		int old;
		for (int i = 0; i < 4; i++) m_board[m_row[i]][m_col[i]] = 1'b1;
		n = 0;
		full = 0;
		while (full >= 0) begin
			full = -1;
			for (int r = 0; r < `BOARD_ROWS; r++) begin
				if (&m_board[r]) full = r;
			end
			if (full >= 0) begin
				for (int r = full; r > 0; r--) m_board[r] = m_board[r-1];
				m_board[0] = '0;
				n++;
			end
		end
		old = m_lines;
		m_lines = m_lines + n;
		m_level = m_level + m_lines / `LINES_PER_LEVEL - old / `LINES_PER_LEVEL;
		if (m_level > (1 << `LEVEL_W) - 1) m_level = (1 << `LEVEL_W) - 1;
		model_spawn(k);
	endtask

	task automatic model_tick(input bit l, input bit r, input bit d, input bit rot,
			input piece_kind_e k);
		int period;
		bit due;
		bit ok;
		if (!m_playing) return; // ticks ignored once the game is over
		if (rot && m_kind != PIECE_O) try_rotate();
		if (l && !r) try_shift(0, -1, ok);
		else if (r && !l) try_shift(0, 1, ok);
		period = `GRAVITY_BASE - m_level;
		if (period < `GRAVITY_MIN) period = `GRAVITY_MIN;
		due = d || (m_grav + 1 >= period);
		m_grav = due ? 0 : m_grav + 1;
		if (due) begin
			try_shift(1, 0, ok);
			if (!ok) model_lock(k);
		end
	endtask

	task automatic model_start(input piece_kind_e k);
		for (int r = 0; r < `BOARD_ROWS; r++) m_board[r] = '0;
		m_lines = 0;
		m_level = 0;
		model_spawn(k);
	endtask

	//============================================================
	// stimulus and checks
	//============================================================
	task automatic add_test(input string name, input bit st, input piece_kind_e k,
			input bit l, input bit r, input bit d, input int rot, input int ticks,
			input int row);
		t_name[n_added] = name;
		t_start[n_added] = st;
		t_kind[n_added] = k;
		t_left[n_added] = l;
		t_right[n_added] = r;
		t_down[n_added] = d;
		t_rot[n_added] = rot;
		t_ticks[n_added] = ticks;
		t_row[n_added] = row;
		n_added++;
	endtask

	task automatic apply_tick();
		@(negedge clk);
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		repeat (TICK_CYCLES - 2) @(negedge clk);
	endtask

	task automatic press_rotate();
		@(negedge clk);
		rotate = 1'b1;
		repeat (2) @(negedge clk);
		rotate = 1'b0;
	endtask

	task automatic launch_game(input string name);
		int delay;
		int waited;
		delay = ($random(seed) & 15) + 1;
		repeat (delay) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		waited = 0;
		while (!playing && waited < 200) begin
			@(negedge clk);
			waited++;
		end
		assert (playing) else begin
			$display("%s: game did not come up within 200 cycles of start", name);
			test_errs++;
		end
	endtask

	task automatic read_row(input int r, output logic [`BOARD_COLS-1:0] v);
		@(negedge clk);
		row_sel = `ROW_W'(r);
		@(negedge clk);
		v = row_bits;
	endtask

	task automatic check_value(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("[FAIL] %s: %s expected 0x%0h, actual 0x%0h", name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_board_empty(input string name);
		logic [`BOARD_COLS-1:0] got;
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			read_row(r, got);
			check_value(name, $sformatf("row %0d", r), 0, got);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d mismatches", name, test_errs);
		end
	endtask

	task automatic check_test(input int i);
		logic [`BOARD_COLS-1:0] got;
		check_value(t_name[i], "lines", t_exp_lines[i], lines);
		check_value(t_name[i], "level", t_exp_level[i], level);
		check_value(t_name[i], "game_over", t_exp_over[i], game_over);
		check_value(t_name[i], "playing", m_playing, playing);
		read_row(t_row[i], got);
		check_value(t_name[i], $sformatf("row %0d", t_row[i]), t_exp_row[i], got);
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			if (r != t_row[i]) begin
				read_row(r, got);
				check_value(t_name[i], $sformatf("row %0d", r), m_board[r], got);
			end
		end
		finish_test(t_name[i]);
	endtask

	initial begin
		reset = 1'b1;
		tick = 1'b0;
		start = 1'b0;
		left = 1'b0;
		right = 1'b0;
		rotate = 1'b0;
		down = 1'b0;
		next_kind = PIECE_I;
		row_sel = '0;
		seed = 61;
		cycle_count = 0;
		cycle_limit = 0;
		pass_count = 0;
		fail_count = 0;
		n_added = 0;
		m_playing = 1'b0;
		m_over = 1'b0;
		m_lines = 0;
		m_level = 0;
		for (int r = 0; r < `BOARD_ROWS; r++) m_board[r] = '0;

		//  name            start kind     L  R  D  rot ticks row
		add_test("drop_i",       1, PIECE_I, 0, 0, 1, 0, 20, 19);
		add_test("wall_left",    0, PIECE_O, 1, 0, 1, 0, 19, 18);
		add_test("stack_over",   0, PIECE_O, 0, 0, 1, 0, 92, 1);
		add_test("restart",      1, PIECE_I, 0, 0, 0, 0, 0, 19);
		add_test("clear_left",   0, PIECE_I, 1, 0, 1, 0, 20, 19);
		add_test("clear_right",  0, PIECE_O, 0, 1, 1, 0, 20, 19);
		add_test("clear_line",   0, PIECE_I, 0, 0, 1, 0, 19, 19);
		add_test("level_left",   0, PIECE_I, 1, 0, 1, 0, 20, 19);
		add_test("level_right",  0, PIECE_O, 0, 1, 1, 0, 20, 19);
		add_test("level_o",      0, PIECE_I, 0, 0, 1, 0, 19, 18);
		add_test("level_left2",  0, PIECE_I, 1, 0, 1, 0, 20, 19);
		add_test("level_right2", 0, PIECE_I, 0, 1, 1, 0, 20, 19);
		add_test("level_left3",  0, PIECE_I, 1, 0, 1, 0, 20, 19);
		add_test("level_right3", 0, PIECE_I, 0, 1, 1, 0, 20, 19);
		add_test("rotate_spawn", 0, PIECE_I, 0, 0, 1, 1, 3, 19);
		add_test("rotate_i",     0, PIECE_O, 0, 0, 1, 1, 16, 16);
		add_test("gravity_wait", 0, PIECE_O, 0, 0, 0, 0, 134, 15);
		add_test("gravity_lock", 0, PIECE_O, 0, 0, 0, 0, 1, 15);

		cycle_limit = 10;
		for (int i = 0; i < N_TESTS; i++) cycle_limit = cycle_limit + t_ticks[i];
		cycle_limit = cycle_limit * TICK_CYCLES;

		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_errs = 0;
		check_value("reset", "playing", 0, playing);
		check_value("reset", "game_over", 0, game_over);
		check_value("reset", "lines", 0, lines);
		check_value("reset", "level", 0, level);
		check_board_empty("reset");
		finish_test("reset");

		for (int i = 0; i < N_TESTS; i++) begin
			test_errs = 0;
			@(negedge clk);
			next_kind = t_kind[i];
			left = t_left[i];
			right = t_right[i];
			down = t_down[i];
			if (t_start[i]) begin
				launch_game(t_name[i]);
				model_start(t_kind[i]);
			end
			for (int k = 1; k <= t_ticks[i]; k++) begin
				if (k == t_rot[i]) press_rotate();
				apply_tick();
				model_tick(t_left[i], t_right[i], t_down[i], k == t_rot[i], t_kind[i]);
			end
			t_exp_lines[i] = m_lines;
			t_exp_level[i] = m_level;
			t_exp_over[i] = m_over;
			t_exp_row[i] = m_board[t_row[i]];
			check_test(i);
		end

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hw/tetris_core.sv ====
`timescale 1ns/1ps
`include "tetris_params.svh"

module tetris_core (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic start,
	input logic left,
	input logic right,
	input logic rotate,
	input logic down,
	input tetris_pkg::piece_kind_e next_kind,
	input logic [`ROW_W-1:0] row_sel,
	output logic [`BOARD_COLS-1:0] row_bits,
	output logic playing,
	output logic game_over,
	output logic [`LINES_W-1:0] lines,
	output logic [`LEVEL_W-1:0] level
);

	piece_if piece_link ();
	board_if board_link ();

	piece_unit u_piece (
		.clk   (clk),
		.reset (reset),
		.piece (piece_link)
	);

	board_store u_board (
		.clk      (clk),
		.reset    (reset),
		.piece    (piece_link),
		.bus      (board_link),
		.row_sel  (row_sel),
		.row_bits (row_bits)
	);

	game_control u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.start     (start),
		.left      (left),
		.right     (right),
		.rotate    (rotate),
		.down      (down),
		.next_kind (next_kind),
		.piece     (piece_link),
		.bus       (board_link),
		.playing   (playing),
		.game_over (game_over),
		.lines     (lines),
		.level     (level)
	);

endmodule

// ==== hw/game_control.sv ====
`timescale 1ns/1ps
`include "tetris_params.svh"

module game_control (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic start,
	input logic left,
	input logic right,
	input logic rotate,
	input logic down,
	input tetris_pkg::piece_kind_e next_kind,
	piece_if.ctrl piece,
	board_if.ctrl bus,
	output logic playing,
	output logic game_over,
	output logic [`LINES_W-1:0] lines,
	output logic [`LEVEL_W-1:0] level
);
	import tetris_pkg::*;

	localparam int LEVEL_MAX = (1 << `LEVEL_W) - 1;

	game_state_e state;
	piece_cmd_e cmd_q;
	piece_cmd_e side_q;    // pending side move, NONE if none
	piece_kind_e kind_q;   // kind of the piece in play
	board_op_e op_q;
	logic sample_q;        // cmd_q is out, hit is valid
	logic req_q;
	logic rotate_d;
	logic rot_edge;
	logic rot_latch;
	logic rot_go;
	logic down_go;
	logic [`LEVEL_W-1:0] grav_cnt;
	logic [`LEVEL_W-1:0] grav_period;
	logic grav_due;
	logic [`LINES_W-1:0] lines_sum;
	logic [`LINES_W-1:0] level_steps;
	logic [`LINES_W:0] level_sum;

	assign piece.cmd = cmd_q;
	assign piece.kind = kind_q;
	assign piece.commit = sample_q && !bus.hit;
	assign bus.op = op_q;
	assign bus.req = req_q;

	assign rot_edge = rotate && !rotate_d;

	// faster with level, floored
	assign grav_period = (level >= `LEVEL_W'(`GRAVITY_BASE - `GRAVITY_MIN)) ?
		`LEVEL_W'(`GRAVITY_MIN) : `LEVEL_W'(`GRAVITY_BASE) - level;
	assign grav_due = (grav_cnt + 1'b1) >= grav_period;

	assign lines_sum = lines + `LINES_W'(bus.cleared);
	assign level_steps = lines_sum / `LINES_PER_LEVEL - lines / `LINES_PER_LEVEL;
	assign level_sum = level_steps + level;

	//==========================================================
	// game FSM
	//==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			cmd_q <= CMD_NONE;
			side_q <= CMD_NONE;
			kind_q <= PIECE_I;
			op_q <= OP_LOCK;
			sample_q <= 1'b0;
			req_q <= 1'b0;
			rotate_d <= 1'b0;
			rot_latch <= 1'b0;
			rot_go <= 1'b0;
			down_go <= 1'b0;
			grav_cnt <= '0;
			playing <= 1'b0;
			game_over <= 1'b0;
			lines <= '0;
			level <= '0;
		end else begin
			rotate_d <= rotate;
			if (rot_edge) rot_latch <= 1'b1;

			case (state)
				ST_IDLE, ST_OVER: begin
					if (start) begin
						rot_latch <= 1'b0;
						op_q <= OP_CLEAR;
						req_q <= 1'b1;
						state <= ST_CLEAR;
					end
				end
				ST_CLEAR, ST_LOCK: begin
					if (req_q && bus.ack) begin
						req_q <= 1'b0;
						if (op_q == OP_LOCK) begin
							lines <= lines_sum;
							level <= (level_sum > LEVEL_MAX) ? `LEVEL_W'(LEVEL_MAX) :
								level_sum[`LEVEL_W-1:0];
						end else begin
							lines <= '0;
							level <= '0;
						end
					end else if (!req_q && !bus.ack) begin
						state <= ST_SPAWN;
					end
				end
				ST_SPAWN: begin
					if (!sample_q) begin
						cmd_q <= CMD_SPAWN;
						kind_q <= next_kind;
						sample_q <= 1'b1;
					end else begin
						sample_q <= 1'b0;
						cmd_q <= CMD_NONE;
						if (bus.hit) begin
							playing <= 1'b0;
							game_over <= 1'b1;
							state <= ST_OVER;
						end else begin
							playing <= 1'b1;
							game_over <= 1'b0;
							grav_cnt <= '0;
							state <= ST_READY;
						end
					end
				end
				ST_READY: begin
					if (tick) begin
						rot_go <= (rot_latch || rot_edge) && (kind_q != PIECE_O);
						rot_latch <= 1'b0;
						side_q <= (left && !right) ? CMD_LEFT :
							(right && !left) ? CMD_RIGHT : CMD_NONE;
						down_go <= down || grav_due;
						grav_cnt <= (down || grav_due) ? '0 : grav_cnt + 1'b1;
						state <= ST_STEP;
					end
				end
				ST_STEP: begin
					if (!sample_q) begin
						// rotate, then side, then down
						sample_q <= 1'b1;
						if (rot_go) begin
							cmd_q <= CMD_ROTATE;
							rot_go <= 1'b0;
						end else if (side_q != CMD_NONE) begin
							cmd_q <= side_q;
							side_q <= CMD_NONE;
						end else if (down_go) begin
							cmd_q <= CMD_DOWN;
							down_go <= 1'b0;
						end else begin
							sample_q <= 1'b0;
							state <= ST_READY;
						end
					end else begin
						sample_q <= 1'b0;
						cmd_q <= CMD_NONE;
						if (cmd_q == CMD_DOWN && bus.hit) begin // landed
							op_q <= OP_LOCK;
							req_q <= 1'b1;
							state <= ST_LOCK;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/board_store.sv ====
`timescale 1ns/1ps
`include "tetris_params.svh"

module board_store (
	input logic clk,
	input logic reset,
	piece_if.board piece,
	board_if.board bus,
	input logic [`ROW_W-1:0] row_sel,
	output logic [`BOARD_COLS-1:0] row_bits
);
	import tetris_pkg::*;

	typedef enum logic [2:0] {
		B_IDLE,
		B_FIND,
		B_SHIFT,
		B_WIPE,
		B_DONE
	} bstate_e;

	logic [`BOARD_COLS-1:0] grid [`BOARD_ROWS]; // row 0 at the top
	bstate_e state;
	logic [`ROW_W-1:0] row_q;
	logic [2:0] cleared_q;
	logic ack_q;
	logic hit;
	logic full_any;
	logic [`ROW_W-1:0] full_row;

	assign bus.hit = hit;
	assign bus.ack = ack_q;
	assign bus.cleared = cleared_q;
	assign row_bits = (row_sel < `BOARD_ROWS) ? grid[row_sel] : '0;

	// probe: off the board or onto a set cell
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (piece.cand[i].row >= `BOARD_ROWS || piece.cand[i].col >= `BOARD_COLS) begin
				hit = 1'b1;
			end else if (grid[piece.cand[i].row][piece.cand[i].col]) begin
				hit = 1'b1;
			end
		end
	end

	// lowest full row wins
	always_comb begin
		full_any = 1'b0;
		full_row = '0;
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			if (&grid[r]) begin
				full_any = 1'b1;
				full_row = `ROW_W'(r);
			end
		end
	end

	//==========================================================
	// board operations
	//==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < `BOARD_ROWS; r++) begin
				grid[r] <= '0;
			end
			state <= B_IDLE;
			row_q <= '0;
			cleared_q <= '0;
			ack_q <= 1'b0;
		end else begin
			case (state)
				B_IDLE: begin
					if (bus.req) begin
						cleared_q <= '0;
						if (bus.op == OP_CLEAR) begin
							row_q <= '0;
							state <= B_WIPE;
						end else begin
							for (int i = 0; i < 4; i++) begin
								grid[piece.cells[i].row][piece.cells[i].col] <= 1'b1;
							end
							state <= B_FIND;
						end
					end
				end
				B_FIND: begin
					if (!full_any) begin
						ack_q <= 1'b1;
						state <= B_DONE;
					end else if (full_row == '0) begin
						grid[0] <= '0; // nothing above to pull down
						cleared_q <= cleared_q + 1'b1;
					end else begin
						row_q <= full_row;
						state <= B_SHIFT;
					end
				end
				B_SHIFT: begin
					// one row per cycle, walking up
					grid[row_q] <= grid[row_q - 1'b1];
					if (row_q == `ROW_W'(1)) begin
						grid[0] <= '0;
						cleared_q <= cleared_q + 1'b1;
						state <= B_FIND;
					end else begin
						row_q <= row_q - 1'b1;
					end
				end
				B_WIPE: begin
					grid[row_q] <= '0;
					if (row_q == `ROW_W'(`BOARD_ROWS - 1)) begin
						ack_q <= 1'b1;
						state <= B_DONE;
					end else begin
						row_q <= row_q + 1'b1;
					end
				end
				B_DONE: begin
					if (!bus.req) begin
						ack_q <= 1'b0;
						state <= B_IDLE;
					end
				end
				default: state <= B_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/piece_unit.sv ====
`timescale 1ns/1ps
`include "tetris_params.svh"

module piece_unit (
	input logic clk,
	input logic reset,
	piece_if.piece piece
);
	import tetris_pkg::*;

	// rotation centre right after spawn
	localparam cell_t PIVOT_I = '{0, 5};
	localparam cell_t PIVOT_STD = '{1, 4};

	cells_t cells_q;
	cell_t pivot_q;
	cells_t cand;
	cell_t cand_pivot;

	assign piece.cand = cand;
	assign piece.cells = cells_q;

	//==========================================================
	// candidate position
	//==========================================================
	always_comb begin : cand_calc
		int dr;
		int dc;
		cand = cells_q;
		cand_pivot = pivot_q;
		dr = 0;
		dc = 0;
		case (piece.cmd)
			CMD_SPAWN: begin
				cand = spawn_cells[piece.kind];
				cand_pivot = (piece.kind == PIECE_I) ? PIVOT_I : PIVOT_STD;
			end
			CMD_LEFT: begin
				for (int i = 0; i < 4; i++) begin
					cand[i].col = cells_q[i].col - 1'b1; // col 0 wraps to 15
				end
				cand_pivot.col = pivot_q.col - 1'b1;
			end
			CMD_RIGHT: begin
				for (int i = 0; i < 4; i++) begin
					cand[i].col = cells_q[i].col + 1'b1;
				end
				cand_pivot.col = pivot_q.col + 1'b1;
			end
			CMD_DOWN: begin
				for (int i = 0; i < 4; i++) begin
					cand[i].row = cells_q[i].row + 1'b1;
				end
				cand_pivot.row = pivot_q.row + 1'b1;
			end
			CMD_ROTATE: begin
				// clockwise, (dr, dc) -> (dc, -dr) around the pivot
				for (int i = 0; i < 4; i++) begin
					dr = int'(cells_q[i].row) - int'(pivot_q.row);
					dc = int'(cells_q[i].col) - int'(pivot_q.col);
					cand[i].row = `ROW_W'(int'(pivot_q.row) + dc);
					cand[i].col = `COL_W'(int'(pivot_q.col) - dr);
				end
			end
			default: begin
				cand = cells_q;
			end
		endcase
	end

	//==========================================================
	// current piece
	//==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			cells_q <= '0;
			pivot_q <= '0;
		end else if (piece.commit) begin
			cells_q <= cand;
			pivot_q <= cand_pivot;
		end
	end

endmodule

// ==== hw/board_if.sv ====
`timescale 1ns/1ps

interface board_if ();
	import tetris_pkg::*;

	board_op_e op;
	logic req;
	logic ack;
	logic hit;            // combinational probe of piece cand
	logic [2:0] cleared;  // rows removed by last lock

	// four-phase: req up, ack up, req down, ack down
	modport ctrl (
		output op,
		output req,
		input ack,
		input hit,
		input cleared
	);

	modport board (
		input op,
		input req,
		output ack,
		output hit,
		output cleared
	);

endinterface

// ==== hw/piece_if.sv ====
`timescale 1ns/1ps

interface piece_if ();
	import tetris_pkg::*;

	piece_cmd_e cmd;    // what to try this step
	piece_kind_e kind;  // used by spawn only
	logic commit;       // one-cycle pulse, take cand
	cells_t cand;
	cells_t cells;      // piece as it stands

	modport ctrl (
		output cmd,
		output kind,
		output commit
	);

	modport piece (
		input cmd,
		input kind,
		input commit,
		output cand,
		output cells
	);

	// probe reads cand, lock reads cells
	modport board (
		input cand,
		input cells
	);

endinterface

// ==== hw/tetris_pkg.sv ====
`include "tetris_params.svh"

package tetris_pkg;

	typedef enum logic [2:0] {
		PIECE_T = 3'b001,
		PIECE_O = 3'b010,
		PIECE_L = 3'b011,
		PIECE_J = 3'b100,
		PIECE_S = 3'b101,
		PIECE_Z = 3'b110,
		PIECE_I = 3'b111
	} piece_kind_e;

	typedef struct packed {
		logic [`ROW_W-1:0] row;
		logic [`COL_W-1:0] col;
	} cell_t;

	typedef cell_t [3:0] cells_t;

	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_SPAWN,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_DOWN,
		CMD_ROTATE
	} piece_cmd_e;

	typedef enum logic {
		OP_LOCK,
		OP_CLEAR
	} board_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SPAWN,
		ST_READY,
		ST_STEP,
		ST_LOCK,
		ST_OVER,
		ST_CLEAR
	} game_state_e;

	// indexed by kind code, cells listed 3 down to 0 as (row, col)
	localparam cells_t spawn_cells [8] = '{
		'{'{0, 0}, '{0, 0}, '{0, 0}, '{0, 0}}, // code 0 unused
		'{'{1, 5}, '{1, 4}, '{1, 3}, '{0, 4}}, // T
		'{'{1, 5}, '{1, 4}, '{0, 5}, '{0, 4}}, // O
		'{'{1, 5}, '{1, 4}, '{1, 3}, '{0, 5}}, // L
		'{'{1, 5}, '{1, 4}, '{1, 3}, '{0, 3}}, // J
		'{'{1, 4}, '{1, 3}, '{0, 5}, '{0, 4}}, // S
		'{'{1, 5}, '{1, 4}, '{0, 4}, '{0, 3}}, // Z
		'{'{0, 6}, '{0, 5}, '{0, 4}, '{0, 3}}  // I
	};

endpackage

// ==== hw/tetris_params.svh ====
`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// playfield geometry
`define BOARD_COLS 10
`define BOARD_ROWS 20
`define ROW_W 5
`define COL_W 4

// counter widths
`define LINES_W 10
`define LEVEL_W 6

// gravity in ticks per step
`define GRAVITY_BASE 10
`define GRAVITY_MIN 1

// level goes up every few cleared lines
`define LINES_PER_LEVEL 4

`endif
